// File: test/packStreamTrace.txt
# columns: command, test name, arguments
# B firstByte(hex) count | S stallCycles bytesAccepted | R 1=random 0=ready | E word(hex)
B order 11 1
B order 22 1
B order 33 1
B order 44 1
E order 44332211
B order a0 8
E order a3a2a1a0
E order a7a6a5a4
R random 1
B random 00 32
E random 03020100
E random 07060504
E random 0b0a0908
E random 0f0e0d0c
E random 13121110
E random 17161514
E random 1b1a1918
E random 1f1e1d1c
R capacity 0
S capacity 120 68
B capacity 40 72
E capacity 43424140
E capacity 47464544
E capacity 4b4a4948
E capacity 4f4e4d4c
E capacity 53525150
E capacity 57565554
E capacity 5b5a5958
E capacity 5f5e5d5c
E capacity 63626160
E capacity 67666564
E capacity 6b6a6968
E capacity 6f6e6d6c
E capacity 73727170
E capacity 77767574
E capacity 7b7a7978
E capacity 7f7e7d7c
E capacity 83828180
E recovery 87868584
B recovery c0 16
E recovery c3c2c1c0
E recovery c7c6c5c4
E recovery cbcac9c8
E recovery cfcecdcc
B leftover f0 3

// File: all.f
verilog/streamPkg.sv
verilog/fifoPkg.sv
verilog/userFifoDual.sv
verilog/fifoDualController.sv
verilog/bytePacker.sv
verilog/wordDrain.sv
verilog/packStreamTop.sv
test/packStreamTb.sv

// File: Bender.yml
package:
  name: pack_stream

sources:
  - verilog/streamPkg.sv
  - verilog/fifoPkg.sv
  - verilog/userFifoDual.sv
  - verilog/fifoDualController.sv
  - verilog/bytePacker.sv
  - verilog/wordDrain.sv
  - verilog/packStreamTop.sv
  - target: test
    files:
      - test/packStreamTb.sv

// File: test/packStreamTb.sv
`timescale 1ns/1ps

module packStreamTb;

    import streamPkg::*;

    logic iClkB;
    logic rstN;
    byteT byteData;
    logic byteValid;
    logic outReady;
    logic byteReady;
    wordT outData;
    logic outValid;

    // trace lines, one entry per command
    string lineCmd [$];
    string lineTest [$];
    int    lineArgA [$];
    int    lineArgB [$];
    wordT  expWords [$];        // E lines in file order
    string expTests [$];

    int    errors;
    int    passCnt;
    int    failCnt;
    int    testErrStart;        // error count when the current test began
    int    outIdx;              // words taken by the sink so far
    int    ePosted;             // E lines the driver has reached
    int    bytesTaken;          // bytes the DUT accepted so far
    int    cycleCnt;
    int    cycleLimit;
    int    stallSum;
    int    stallLeft;           // sink stall cycles still to go
    int    stallCap;            // bytes the DUT should swallow during the stall
    int    stallAcc;
    string stallTest;
    string curTest;
    logic  randMode;            // outReady from xorshift
    logic  byteTaken;           // host handshake seen on the last edge
    logic  traceOk;
    logic [31:0] rngState;

    packStreamTop dut (
        .iClkB     (iClkB),
        .rstN      (rstN),
        .byteData  (byteData),
        .byteValid (byteValid),
        .outReady  (outReady),
        .byteReady (byteReady),
        .outData   (outData),
        .outValid  (outValid)
    );

    initial
    begin
        iClkB = 1'b0;
        forever #4 iClkB = ~iClkB;      // 8 ns period
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkWord(input string testName, input wordT expWord, input wordT actWord);
        if (actWord !== expWord)
        begin
            $display("mismatch test %s word: expected %h, actual %h", testName, expWord, actWord);
            errors++;
        end
    endtask

    task automatic checkFlag(input string testName, input string flagName,
                             input logic expFlag, input logic actFlag);
        if (actFlag !== expFlag)
        begin
            $display("mismatch test %s %s: expected %b, actual %b",
                     testName, flagName, expFlag, actFlag);
            errors++;
        end
    endtask

    task automatic checkCount(input string testName, input string what,
                              input int expCnt, input int actCnt);
        if (actCnt != expCnt)
        begin
            $display("mismatch test %s %s: expected %0d, actual %0d",
                     testName, what, expCnt, actCnt);
            errors++;
        end
    endtask

    // ------------------------------
    // trace file
    // ------------------------------
    task automatic readTrace(output logic ok);
        int    fd;
        int    n;
        int    c;
        int    a;
        int    b;
        string cmd;
        string tname;
        fd = $fopen("test/packStreamTrace.txt", "r");
        ok = (fd != 0);
        stallSum = 0;
        while (ok && !$feof(fd))
        begin
            n = $fscanf(fd, "%s", cmd);
            if (n != 1)
                break;
            if (cmd.substr(0, 0) == "#")
            begin
                do
                    c = $fgetc(fd);     // skip the rest of a comment line
                while (c != 10 && c != -1);
            end
            else
            begin
                n = $fscanf(fd, "%s", tname);
                a = 0;
                b = 0;
                if (cmd == "B")
                    n = $fscanf(fd, "%h %d", a, b);     // first byte, byte count
                else if (cmd == "S")
                begin
                    n = $fscanf(fd, "%d %d", a, b);     // cycles, bytes before block
                    stallSum += a;
                end
                else if (cmd == "R")
                    n = $fscanf(fd, "%d", a);
                else if (cmd == "E")
                begin
                    n = $fscanf(fd, "%h", a);
                    expWords.push_back(wordT'(a));
                    expTests.push_back(tname);
                end
                else
                begin
                    $display("trace file holds an unknown command %s", cmd);
                    errors++;
                end
                lineCmd.push_back(cmd);
                lineTest.push_back(tname);
                lineArgA.push_back(a);
                lineArgB.push_back(b);
            end
        end
        if (fd != 0)
            $fclose(fd);
    endtask

    // ------------------------------
    // per cycle driving
    // ------------------------------
    // samples on the edge, drives 1 ns later
    task automatic tick();
        @(posedge iClkB);
        byteTaken = byteValid & byteReady;
        if (stallLeft > 0 && byteTaken)
            stallAcc++;
        if (stallLeft == 1 && stallCap > 0)     // last stalled edge
        begin
            checkFlag(stallTest, "byteReady at end of stall", 1'b0, byteReady);
            checkCount(stallTest, "bytes accepted during stall", stallCap, stallAcc);
        end
        #1;
        if (stallLeft > 0)
            stallLeft--;
        if (stallLeft > 0)
            outReady = 1'b0;
        else if (randMode)
        begin
            rngState = xorshift(rngState);
            outReady = rngState[0];
        end
        else
            outReady = 1'b1;
    endtask

    task automatic pushBytes(input int first, input int count);
        int i;
        for (i = 0; i < count; i++)
        begin
            byteData  = byteT'(first + i);      // counting pattern
            byteValid = 1'b1;
            do
                tick();
            while (!byteTaken);
            bytesTaken++;
        end
        byteValid = 1'b0;
    endtask

    // drain what the test expects and every whole word pushed so far, then report it
    task automatic endTest(input string name);
        while (outIdx < ePosted || outIdx < bytesTaken / BYTES_PER_WORD)
            tick();
        checkFlag(name, "byteReady after drain", 1'b1, byteReady);
        checkFlag(name, "outValid after drain", 1'b0, outValid);
        if (errors == testErrStart)
        begin
            $display("test %s: ok", name);
            passCnt++;
        end
        else
        begin
            $display("test %s: failed with %0d errors", name, errors - testErrStart);
            failCnt++;
        end
        testErrStart = errors;
    endtask

    task automatic runTrace();
        int i;
        for (i = 0; i < lineCmd.size(); i++)
        begin
            if (lineTest[i] != curTest)
            begin
                endTest(curTest);
                curTest = lineTest[i];
            end
            if (lineCmd[i] == "B")
                pushBytes(lineArgA[i], lineArgB[i]);
            else if (lineCmd[i] == "S")
            begin
                stallLeft = lineArgA[i];
                stallCap  = lineArgB[i];
                stallAcc  = 0;
                stallTest = curTest;
                outReady  = 1'b0;       // stall starts right away
            end
            else if (lineCmd[i] == "R")
                randMode = (lineArgA[i] != 0);
            else if (lineCmd[i] == "E")
                ePosted++;
        end
    endtask

    // ------------------------------
    // sink monitor and watchdog
    // ------------------------------
    always @(posedge iClkB)
    begin
        if (rstN && outValid && outReady)
        begin
            if (outIdx < expWords.size())
                checkWord(expTests[outIdx], expWords[outIdx], outData);
            else
            begin
                $display("unexpected output word %h after all expected words", outData);
                errors++;
            end
            outIdx++;
        end
    end

    always @(posedge iClkB)
    begin
        cycleCnt++;
        if (cycleLimit > 0 && cycleCnt > cycleLimit)
        begin
            $display("timeout after %0d cycles, the stream stopped making progress", cycleCnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial
    begin
        rstN = 1'b0;
        byteData = '0;
        byteValid = 1'b0;
        outReady = 1'b1;
        randMode = 1'b0;
        rngState = 32'd25110;
        errors = 0;
        passCnt = 0;
        failCnt = 0;
        testErrStart = 0;
        outIdx = 0;
        ePosted = 0;
        bytesTaken = 0;
        cycleCnt = 0;
        cycleLimit = 0;
        stallLeft = 0;
        stallCap = 0;
        stallAcc = 0;
        readTrace(traceOk);
        cycleLimit = (lineCmd.size() + stallSum) * 8 + 200;
        if (!traceOk)
        begin
            $display("could not open test/packStreamTrace.txt, nothing to run");
            $display("STATUS: FAIL");
            $finish;
        end
        else
        begin
            repeat (10) @(posedge iClkB);
            #1;
            rstN = 1'b1;
            checkFlag("reset", "outValid", 1'b0, outValid);
            checkFlag("reset", "byteReady", 1'b1, byteReady);
            curTest = "reset";
            runTrace();
            repeat (20) tick();     // leftover bytes must stay in the packer
            checkCount(curTest, "output words", expWords.size(), outIdx);
            endTest(curTest);
            $display("tests passed %0d, failed %0d", passCnt, failCnt);
            if (errors == 0 && failCnt == 0)
                $display("STATUS: PASS");
            else
                $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule

// File: verilog/packStreamTop.sv
`timescale 1ns/1ps

module packStreamTop (
    input  logic            iClkB,
    input  logic            rstN,
    input  streamPkg::byteT byteData,
    input  logic            byteValid,
    input  logic            outReady,
    output logic            byteReady,
    output streamPkg::wordT outData,
    output logic            outValid
);

    import streamPkg::*;

    wordT wrData;           // packer -> buffer
    logic wrEn;
    wordT rdData;           // buffer -> drain
    logic rdEn;
    logic empty;
    logic creditReturn;     // drain -> packer

    // ------------------------------
    // producer
    // ------------------------------
    bytePacker uPacker (
        .iClkB        (iClkB),
        .rstN         (rstN),
        .byteData     (byteData),
        .byteValid    (byteValid),
        .creditReturn (creditReturn),
        .byteReady    (byteReady),
        .wrData       (wrData),
        .wrEn         (wrEn)
    );

    // ------------------------------
    // buffer
    // ------------------------------
    // full left open, credits keep the packer off it
    fifoDualController uBuffer (
        .iClkB        (iClkB),
        .rstN         (rstN),
        .wrData       (wrData),
        .wrEn         (wrEn),
        .rdEn         (rdEn),
        .full         (),
        .rdData       (rdData),
        .empty        (empty)
    );

    // ------------------------------
    // consumer
    // ------------------------------
    wordDrain uDrain (
        .iClkB        (iClkB),
        .rstN         (rstN),
        .rdData       (rdData),
        .empty        (empty),
        .outReady     (outReady),
        .rdEn         (rdEn),
        .creditReturn (creditReturn),
        .outData      (outData),
        .outValid     (outValid)
    );

endmodule

// File: verilog/wordDrain.sv
`timescale 1ns/1ps

module wordDrain (
    input  logic            iClkB,
    input  logic            rstN,
    input  streamPkg::wordT rdData,
    input  logic            empty,
    input  logic            outReady,
    output logic            rdEn,
    output logic            creditReturn,
    output streamPkg::wordT outData,
    output logic            outValid
);

    logic regFree;      // output register can take a new word this cycle

    // ------------------------------
    // pop decision
    // ------------------------------
    assign regFree = ~outValid | outReady;     // empty, or sink takes it now
    assign rdEn    = ~empty & regFree;         // rdData already valid when !empty

    // ------------------------------
    // output register and credit pulse
    // ------------------------------
    always_ff @(posedge iClkB or negedge rstN)
    begin
        if (!rstN)
        begin
            outValid     <= 1'b0;
            creditReturn <= 1'b0;
        end
        else
        begin
            creditReturn <= rdEn;               // one pulse per pop, a cycle late
            if (rdEn)
            begin
                outValid <= 1'b1;
            end
            else if (outReady)
            begin
                outValid <= 1'b0;               // sink took the last one
            end
        end
    end

    // payload only, valid bit above qualifies it
    always_ff @(posedge iClkB)
    begin
        if (rdEn)
        begin
            outData <= rdData;
        end
    end

endmodule

// File: verilog/bytePacker.sv
`timescale 1ns/1ps

module bytePacker (
    input  logic            iClkB,
    input  logic            rstN,
    input  streamPkg::byteT byteData,
    input  logic            byteValid,
    input  logic            creditReturn,
    output logic            byteReady,
    output streamPkg::wordT wrData,
    output logic            wrEn
);

    import streamPkg::*;
    import fifoPkg::*;

    packStateT state;
    packStateT stateNext;
    logic      byteTake;                                    // host handshake
    logic [(BYTES_PER_WORD-1)*BYTE_W-1:0] asmBytes;         // lanes 0..2 so far
    wordT      pendWord;                                    // finished word
    logic [CREDIT_W-1:0] creditCnt;                         // free FIFO slots

    // ------------------------------
    // handshakes
    // ------------------------------
    assign byteReady = (state != stHold);           // only blocked while parked
    assign byteTake  = byteValid & byteReady;
    assign wrEn      = (state == stHold) & (creditCnt != '0);
    assign wrData    = pendWord;

    // ------------------------------
    // FSM
    // ------------------------------
    always_comb
    begin
        stateNext = state;
        case (state)
            stByte0: if (byteTake) stateNext = stByte1;
            stByte1: if (byteTake) stateNext = stByte2;
            stByte2: if (byteTake) stateNext = stByte3;
            stByte3: if (byteTake) stateNext = stHold;    // word done
            stHold:  if (wrEn)     stateNext = stByte0;   // spent a credit
            default: stateNext = stByte0;
        endcase
    end

    always_ff @(posedge iClkB or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= stByte0;
        end
        else
        begin
            state <= stateNext;
        end
    end

    // ------------------------------
    // assembly
    // ------------------------------
    // bytes enter at the top and shift down, so b0 ends in lane 0
    always_ff @(posedge iClkB)
    begin
        if (byteTake)
        begin
            if (state == stByte3)
            begin
                pendWord <= {byteData, asmBytes};   // b3 in bits 31:24
            end
            else
            begin
                asmBytes <= {byteData, asmBytes[$high(asmBytes):BYTE_W]};
            end
        end
    end

    // ------------------------------
    // credits
    // ------------------------------
    // return and spend may land on the same edge
    always_ff @(posedge iClkB or negedge rstN)
    begin
        if (!rstN)
        begin
            creditCnt <= CREDIT_INIT;
        end
        else
        begin
            creditCnt <= creditCnt + CREDIT_W'(creditReturn) - CREDIT_W'(wrEn);
        end
    end

    // drain must never hand back more than were issued
    assert property (@(posedge iClkB) disable iff (!rstN) creditCnt <= CREDIT_INIT)
        else $error("credit count above initial value");

endmodule

// File: verilog/fifoDualController.sv
`timescale 1ns/1ps

module fifoDualController (
    input  logic            iClkB,
    input  logic            rstN,
    input  streamPkg::wordT wrData,
    input  logic            wrEn,
    input  logic            rdEn,
    output logic            full,
    output streamPkg::wordT rdData,
    output logic            empty
);

    import streamPkg::*;
    import fifoPkg::*;

    addrT wrAddr;           // next slot to fill
    addrT rdAddr;           // oldest valid slot
    addrT wrAddrNext;       // look-ahead for full
    logic wrQual;           // write that actually happens
    logic rdQual;           // pop that actually happens

    // ------------------------------
    // flags and qualified enables
    // ------------------------------
    always_comb
    begin
        wrAddrNext = wrAddr + ADDR_W'(1);
        full       = (wrAddrNext == rdAddr);   // one slot kept open
        empty      = (wrAddr == rdAddr);
        wrQual     = wrEn & ~full;              // drop writes into a full buffer
        rdQual     = rdEn & ~empty;             // no pop from an empty one
    end

    // ------------------------------
    // pointers
    // ------------------------------
    always_ff @(posedge iClkB or negedge rstN)
    begin
        if (!rstN)
        begin
            wrAddr <= '0;
        end
        else if (wrQual)
        begin
            wrAddr <= wrAddrNext;   // wraps at depth
        end
    end

    always_ff @(posedge iClkB or negedge rstN)
    begin
        if (!rstN)
        begin
            rdAddr <= '0;
        end
        else if (rdQual)
        begin
            rdAddr <= rdAddr + ADDR_W'(1);
        end
    end

    // storage, read data follows rdAddr directly
    userFifoDual #(
        .depth     (FIFO_DEPTH),
        .width     (WORD_W)
    ) uFifoRam (
        .iClkB     (iClkB),
        .writeData (wrData),
        .writeAddr (wrAddr),
        .readAddr  (rdAddr),
        .writeEn   (wrQual),
        .readData  (rdData)
    );

    // ------------------------------
    // checks
    // ------------------------------
    // packer credit count has to keep it away from a full buffer
    assert property (@(posedge iClkB) disable iff (!rstN) wrEn |-> !full)
        else $error("write issued while FIFO full");

endmodule

// File: verilog/userFifoDual.sv
`timescale 1ns/1ps

module userFifoDual #(
    parameter int depth = 16,           // entries
    parameter int width = 32            // bits per entry
)(
    input  logic             iClkB,
    input  logic [width-1:0] writeData,
    input  fifoPkg::addrT    writeAddr,
    input  fifoPkg::addrT    readAddr,
    input  logic             writeEn,
    output logic [width-1:0] readData
);

    // distributed RAM, maps to LUTs
    logic [width-1:0] mem [depth];

    // ------------------------------
    // write port
    // ------------------------------
    always_ff @(posedge iClkB)
    begin
        if (writeEn)
        begin
            mem[writeAddr] <= writeData;    // lands on this edge
        end
    end

    // ------------------------------
    // read port
    // ------------------------------
    // async read, zero latency from the pointer
    assign readData = mem[readAddr];

endmodule

// File: verilog/fifoPkg.sv
package fifoPkg;

    // ------------------------------
    // buffer geometry
    // ------------------------------
    localparam int FIFO_DEPTH = 16;                     // LUT-RAM entries
    localparam int ADDR_W     = $clog2(FIFO_DEPTH);     // pointer bits
    localparam int CREDIT_W   = ADDR_W + 1;             // room for a full count

    // full is flagged one slot early (wr+1 == rd),
    // so only depth-1 entries are usable
    localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(FIFO_DEPTH - 1);

    // read / write pointer
    typedef logic [ADDR_W-1:0] addrT;

endpackage

// File: verilog/streamPkg.sv
package streamPkg;

    // ------------------------------
    // stream format
    // ------------------------------
    localparam int BYTE_W         = 8;                  // host side byte
    localparam int WORD_W         = 32;                 // buffer / sink word
    localparam int BYTES_PER_WORD = WORD_W / BYTE_W;    // lanes per word

    // payload types
    typedef logic [BYTE_W-1:0] byteT;
    typedef logic [WORD_W-1:0] wordT;

    // ------------------------------
    // packer FSM
    // ------------------------------
    // one state per lane, then a parking state for the finished word
    typedef enum logic [2:0]
    {
        stByte0 = 3'd0,     // waiting for lane 0, bits 7:0
        stByte1 = 3'd1,
        stByte2 = 3'd2,
        stByte3 = 3'd3,     // last lane, completes the word
        stHold  = 3'd4      // word complete, waiting for a credit
    } packStateT;

endpackage
